// File: psram_params.svh
// sizes and timing for the psram bridge model; the model keeps only the low word address bits

`ifndef PSRAM_PARAMS_SVH
`define PSRAM_PARAMS_SVH

// ------------------------------------------------------------
// address widths
// ------------------------------------------------------------
`define PSRAM_BYTE_ADDR_W	22	// byte address on the request side
`define PSRAM_WORD_ADDR_W	21	// byte address without bit 0

// ------------------------------------------------------------
// core model
// ------------------------------------------------------------
`define PSRAM_MODEL_DEPTH_W	8	// stored word address bits, higher bits alias

// cycles from reset release to init_done
`define PSRAM_INIT_CYCLES	20

// cmd_en cycle to rd_valid cycle
`define PSRAM_READ_LATENCY	4

// extra busy cycles after a write is accepted
`define PSRAM_WRITE_WAIT	3

`endif

// File: psram_pkg.sv
// types for the dual psram bridge; a mask bit of 1 leaves that byte lane unwritten
package psram_pkg;

	// ------------------------------------------------------------
	// word side command
	// ------------------------------------------------------------
	typedef enum logic {
		PSRAM_CMD_READ	= 1'b0,	// read one word
		PSRAM_CMD_WRITE	= 1'b1	// masked word write
	} psram_cmd_e;

	// ------------------------------------------------------------
	// byte port channel state
	// ------------------------------------------------------------
	typedef enum logic [1:0] {
		PORT_INIT	= 2'd0,	// waiting for core init_done
		PORT_IDLE	= 2'd1,	// ready for a request
		PORT_WRITE	= 2'd2,	// write issued, counting wait
		PORT_READ	= 2'd3	// read issued, until rdata_en
	} port_state_e;

	// one memory word
	// byte lanes 31:24 even byte, 23:16 odd byte
	typedef logic [31:0] psram_word_t;

	// one bit per byte lane
	// bit 3 guards 31:24, bit 0 guards 7:0
	typedef logic [3:0] psram_mask_t;

endpackage

// File: psram_word_if.sv
// one channel between a byte port and its word core; cmd_en and rd_valid are single cycle pulses
`timescale 1ns/1ps
`include "psram_params.svh"

interface psram_word_if;
	import psram_pkg::*;

	// ------------------------------------------------------------
	// command side, from the byte port
	// ------------------------------------------------------------
	psram_cmd_e					cmd;		// read or write
	logic						cmd_en;		// one cycle, qualifies the rest
	logic [`PSRAM_WORD_ADDR_W-1:0]	addr;		// word address
	psram_word_t				wr_data;	// byte in both upper lanes
	psram_mask_t				mask;		// 1 = lane kept

	// ------------------------------------------------------------
	// return side, from the word core
	// ------------------------------------------------------------
	psram_word_t				rd_data;	// valid with rd_valid
	logic						rd_valid;	// one cycle pulse
	logic						init_done;	// stays high once set

	// byte port view
	modport ctrl (
		output	cmd,
		output	cmd_en,
		output	addr,
		output	wr_data,
		output	mask,
		input	rd_data,
		input	rd_valid,
		input	init_done
	);

	// memory core view
	modport core (
		input	cmd,
		input	cmd_en,
		input	addr,
		input	wr_data,
		input	mask,
		output	rd_data,
		output	rd_valid,
		output	init_done
	);

endinterface

// File: psram_byte_port.sv
// single byte request adapter with no request queue so busy is the only back pressure
`timescale 1ns/1ps
`include "psram_params.svh"

module psram_byte_port (
	input	logic							sys_clk,
	input	logic							n_reset,
	input	logic							rd,			// read request
	input	logic							wr,			// write request, wins over rd
	input	logic [`PSRAM_BYTE_ADDR_W-1:0]	address,	// byte address
	input	logic [7:0]						wdata,
	output	logic							busy,
	output	logic [7:0]						rdata,
	output	logic							rdata_en,	// one cycle pulse
	psram_word_if.ctrl						mem
);
	import psram_pkg::*;

	localparam int WAIT_W = $clog2(`PSRAM_WRITE_WAIT + 2);

	port_state_e		state;
	logic [WAIT_W-1:0]	wait_cnt;	// write wait countdown
	logic				accept;		// request taken this cycle
	logic				rd_lsb;		// byte select for the pending read

	// lane mask for one byte write
	// even byte in 31:24, odd byte in 23:16, low half never written
	function automatic psram_mask_t mask_decode(input logic lsb, input logic is_wr);
		psram_mask_t m;
		if (!is_wr) begin
			m = 4'b1111;		// reads touch nothing
		end else if (lsb) begin
			m = 4'b1011;		// odd byte
		end else begin
			m = 4'b0111;		// even byte
		end
		return m;
	endfunction

	// ------------------------------------------------------------
	// request acceptance and busy
	// ------------------------------------------------------------
	assign accept	= (state == PORT_IDLE) && (rd || wr);
	assign busy		= (state != PORT_IDLE);	// high in init too

	always_ff @(posedge sys_clk) begin
		if (!n_reset) begin
			state		<= PORT_INIT;
			wait_cnt	<= '0;
		end else begin
			case (state)
				PORT_INIT: begin
					if (mem.init_done) begin
						state <= PORT_IDLE;	// busy drops next cycle
					end
				end
				PORT_IDLE: begin
					if (wr) begin
						state		<= PORT_WRITE;
						wait_cnt	<= WAIT_W'(`PSRAM_WRITE_WAIT);
					end else if (rd) begin
						state <= PORT_READ;
					end
				end
				PORT_WRITE: begin
					if (wait_cnt == '0) begin
						state <= PORT_IDLE;
					end else begin
						wait_cnt <= wait_cnt - WAIT_W'(1);
					end
				end
				PORT_READ: begin
					// leave only once the byte has gone out
					if (rdata_en) begin
						state <= PORT_IDLE;
					end
				end
				default: begin
					state <= PORT_INIT;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// word command
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (!n_reset) begin
			mem.cmd_en <= 1'b0;
		end else begin
			mem.cmd_en <= accept;	// cycle after acceptance
		end
	end

	// payload sampled with the request
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			mem.cmd		<= wr ? PSRAM_CMD_WRITE : PSRAM_CMD_READ;
			mem.addr	<= address[`PSRAM_BYTE_ADDR_W-1:1];
			mem.wr_data	<= {wdata, wdata, 16'h0000};	// same byte in both upper lanes
			mem.mask	<= mask_decode(address[0], wr);
			rd_lsb		<= address[0];
		end
	end

	// ------------------------------------------------------------
	// read return
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (!n_reset) begin
			rdata_en <= 1'b0;
		end else begin
			rdata_en <= mem.rd_valid && (state == PORT_READ);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (mem.rd_valid) begin
			rdata <= rd_lsb ? mem.rd_data[23:16] : mem.rd_data[31:24];	// pick addressed lane
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	// read data only leaves while the read is still owned
	a_rdata_in_read: assert property (@(posedge sys_clk) disable iff (!n_reset)
		rdata_en |-> (state == PORT_READ))
		else $error("rdata_en outside PORT_READ");

	// a command only goes out in the first busy cycle after an idle one
	a_cmd_after_accept: assert property (@(posedge sys_clk) disable iff (!n_reset)
		mem.cmd_en |-> (busy && !$past(busy)))
		else $error("cmd_en without a fresh acceptance");

endmodule

// File: psram_word_core.sv
// behavioral stand in for the psram controller on sys_clk with no ddr pins and aliasing storage
`timescale 1ns/1ps
`include "psram_params.svh"

module psram_word_core (
	input	logic			sys_clk,
	input	logic			n_reset,
	psram_word_if.core		bus
);
	import psram_pkg::*;

	localparam int DEPTH	= 1 << `PSRAM_MODEL_DEPTH_W;
	localparam int INIT_W	= $clog2(`PSRAM_INIT_CYCLES + 1);
	localparam int LAT		= `PSRAM_READ_LATENCY;

	logic [INIT_W-1:0]					init_cnt;
	psram_word_t						mem_q [DEPTH];	// word storage
	logic [`PSRAM_MODEL_DEPTH_W-1:0]	idx;			// low word address bits
	logic								is_wr;
	logic								is_rd;
	logic [LAT-1:0]						rd_vld_q;		// read request shift
	psram_word_t						rd_dat_q [LAT];	// word travels with it

	assign idx		= bus.addr[`PSRAM_MODEL_DEPTH_W-1:0];	// upper bits alias
	assign is_wr	= bus.cmd_en && (bus.cmd == PSRAM_CMD_WRITE);
	assign is_rd	= bus.cmd_en && (bus.cmd == PSRAM_CMD_READ);

	// ------------------------------------------------------------
	// init countdown
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (!n_reset) begin
			init_cnt		<= '0;
			bus.init_done	<= 1'b0;
		end else if (!bus.init_done) begin
			init_cnt <= init_cnt + INIT_W'(1);
			if (init_cnt == INIT_W'(`PSRAM_INIT_CYCLES - 1)) begin
				bus.init_done <= 1'b1;	// sticky until reset
			end
		end
	end

	// ------------------------------------------------------------
	// masked word write
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (is_wr) begin
			for (int b = 0; b < 4; b++) begin
				if (!bus.mask[b]) begin
					mem_q[idx][b*8 +: 8] <= bus.wr_data[b*8 +: 8];	// lane by lane
				end
			end
		end
	end

	// ------------------------------------------------------------
	// read pipeline
	// ------------------------------------------------------------
	// word taken at issue, so a later write to the same word does not leak in
	always_ff @(posedge sys_clk) begin
		if (!n_reset) begin
			rd_vld_q <= '0;
		end else begin
			rd_vld_q[0] <= is_rd;
			for (int i = 1; i < LAT; i++) begin
				rd_vld_q[i] <= rd_vld_q[i-1];
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (is_rd) begin
			rd_dat_q[0] <= mem_q[idx];
		end
		for (int i = 1; i < LAT; i++) begin
			rd_dat_q[i] <= rd_dat_q[i-1];	// several reads may be in flight
		end
	end

	assign bus.rd_valid	= rd_vld_q[LAT-1];
	assign bus.rd_data	= rd_dat_q[LAT-1];

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	// the byte port must hold off until the core is ready
	a_no_cmd_before_init: assert property (@(posedge sys_clk) disable iff (!n_reset)
		bus.cmd_en |-> bus.init_done)
		else $error("cmd_en before init_done");

	// every returned word belongs to a read issued exactly LAT cycles back
	a_rd_valid_latency: assert property (@(posedge sys_clk) disable iff (!n_reset)
		bus.rd_valid |-> $past(bus.cmd_en && (bus.cmd == PSRAM_CMD_READ), LAT))
		else $error("rd_valid without a matching read");

endmodule

// File: psram_dual_bridge.sv
// two independent byte channels each on its own word core with all logic on sys_clk
`timescale 1ns/1ps
`include "psram_params.svh"

module psram_dual_bridge (
	input	logic							sys_clk,
	input	logic							n_reset,
	output	logic							initial_busy,	// until both cores are ready
	// channel 0
	input	logic							rd0,
	input	logic							wr0,
	output	logic							busy0,
	input	logic [`PSRAM_BYTE_ADDR_W-1:0]	address0,
	input	logic [7:0]						wdata0,
	output	logic [7:0]						rdata0,
	output	logic							rdata0_en,
	// channel 1
	input	logic							rd1,
	input	logic							wr1,
	output	logic							busy1,
	input	logic [`PSRAM_BYTE_ADDR_W-1:0]	address1,
	input	logic [7:0]						wdata1,
	output	logic [7:0]						rdata1,
	output	logic							rdata1_en
);

	psram_word_if u_bus0 ();	// channel 0 word link
	psram_word_if u_bus1 ();	// channel 1 word link

	// ------------------------------------------------------------
	// channel 0
	// ------------------------------------------------------------
	psram_byte_port u_port0 (
		.sys_clk	(sys_clk),
		.n_reset	(n_reset),
		.rd			(rd0),
		.wr			(wr0),
		.address	(address0),
		.wdata		(wdata0),
		.busy		(busy0),
		.rdata		(rdata0),
		.rdata_en	(rdata0_en),
		.mem		(u_bus0.ctrl)
	);

	psram_word_core u_core0 (
		.sys_clk	(sys_clk),
		.n_reset	(n_reset),
		.bus		(u_bus0.core)
	);

	// ------------------------------------------------------------
	// channel 1
	// ------------------------------------------------------------
	psram_byte_port u_port1 (
		.sys_clk	(sys_clk),
		.n_reset	(n_reset),
		.rd			(rd1),
		.wr			(wr1),
		.address	(address1),
		.wdata		(wdata1),
		.busy		(busy1),
		.rdata		(rdata1),
		.rdata_en	(rdata1_en),
		.mem		(u_bus1.ctrl)
	);

	psram_word_core u_core1 (
		.sys_clk	(sys_clk),
		.n_reset	(n_reset),
		.bus		(u_bus1.core)
	);

	// busy while either core is still initializing
	assign initial_busy = ~u_bus0.init_done | ~u_bus1.init_done;

endmodule

// File: tb_psram_dual_bridge.sv
// dual psram bridge testbench; high address bits alias and each channel runs one request
`timescale 1ns/1ps
`include "psram_params.svh"

module tb_psram_dual_bridge;

	localparam int CLK_PERIOD	= 8;
	localparam int LAT			= `PSRAM_READ_LATENCY;
	localparam int WWAIT		= `PSRAM_WRITE_WAIT;
	localparam int REF_W		= `PSRAM_MODEL_DEPTH_W + 1;	// byte index bits kept by the model
	localparam int OP_CYCLES	= LAT + WWAIT + 8;		// worst single request incl idle wait
	localparam int OP_SLOTS		= 4 + 6 + 2 + 3 + 200;
	localparam int BUDGET		= 5 + `PSRAM_INIT_CYCLES + 4 + OP_SLOTS * OP_CYCLES;
	localparam logic [`PSRAM_BYTE_ADDR_W-1:0] ADDR_WINDOW = 22'h3fff1f;	// 64 byte slots

	logic							sys_clk;
	logic							n_reset;
	logic							initial_busy;
	logic [1:0]						rd;
	logic [1:0]						wr;
	logic [1:0]						busy;
	logic [1:0]						rdata_en;
	logic [`PSRAM_BYTE_ADDR_W-1:0]	address [2];
	logic [7:0]						wdata [2];
	logic [7:0]						rdata [2];

	// reference model with one byte array per channel
	logic [7:0]		ref_mem [2][1 << REF_W];
	logic			ref_vld [2][1 << REF_W];
	int				reads_issued [2];
	int				pulses_seen [2];
	int				errors;
	int				errors_at_start;
	int				tests_run;
	int				tests_failed;
	string			test_name;
	logic [31:0]	rng_state;

	psram_dual_bridge u_psram_dual_bridge (
		.sys_clk		(sys_clk),
		.n_reset		(n_reset),
		.initial_busy	(initial_busy),
		.rd0			(rd[0]),
		.wr0			(wr[0]),
		.busy0			(busy[0]),
		.address0		(address[0]),
		.wdata0			(wdata[0]),
		.rdata0			(rdata[0]),
		.rdata0_en		(rdata_en[0]),
		.rd1			(rd[1]),
		.wr1			(wr[1]),
		.busy1			(busy[1]),
		.address1		(address[1]),
		.wdata1			(wdata[1]),
		.rdata1			(rdata[1]),
		.rdata1_en		(rdata_en[1])
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	// watchdog at twice the summed budget
	initial begin
		#(2 * BUDGET * CLK_PERIOD);
		$display("watchdog expired, the tests did not finish in time");
		$display("Test failures found");
		$finish;
	end

	// count read pulses from pre-edge values
	always @(posedge sys_clk) begin
		if (rdata_en[0]) pulses_seen[0]++;
		if (rdata_en[1]) pulses_seen[1]++;
	end

	// ------------------------------------------------------------
	// protocol assertions
	// ------------------------------------------------------------
	a_rdata0_pulse: assert property (@(posedge sys_clk) disable iff (!n_reset)
		rdata_en[0] |=> !rdata_en[0])
		else begin
			errors++;
			$display("%s: rdata0_en stayed high for more than one cycle", test_name);
		end

	a_rdata1_pulse: assert property (@(posedge sys_clk) disable iff (!n_reset)
		rdata_en[1] |=> !rdata_en[1])
		else begin
			errors++;
			$display("%s: rdata1_en stayed high for more than one cycle", test_name);
		end

	a_init_busy: assert property (@(posedge sys_clk) disable iff (!n_reset)
		initial_busy |-> (busy[0] && busy[1]))
		else begin
			errors++;
			$display("%s: a channel was not busy while initial_busy was high", test_name);
		end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			errors++;
			$display("FAILED %s: %s expected %0h actual %0h", test_name, what, expected, actual);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		check_value("rdata0_en pulses", reads_issued[0], pulses_seen[0]);	// no extra pulse
		check_value("rdata1_en pulses", reads_issued[1], pulses_seen[1]);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	task automatic wait_idle(input int ch);
		@(negedge sys_clk);
		while (busy[ch]) @(negedge sys_clk);
	endtask

	// write and count busy cycles after acceptance
	task automatic drive_write(input int ch, input logic [`PSRAM_BYTE_ADDR_W-1:0] addr,
			input logic [7:0] data);
		int n;
		wait_idle(ch);
		@(posedge sys_clk);
		wr[ch]		<= 1'b1;
		address[ch]	<= addr;
		wdata[ch]	<= data;
		@(posedge sys_clk);	// accepted on this edge
		wr[ch] <= 1'b0;
		ref_mem[ch][addr[REF_W-1:0]] = data;
		ref_vld[ch][addr[REF_W-1:0]] = 1'b1;
		n = 0;
		@(negedge sys_clk);
		while (busy[ch] && n < OP_CYCLES) begin
			n++;
			@(negedge sys_clk);
		end
		check_value($sformatf("ch%0d write busy cycles", ch), WWAIT + 1, n);
	endtask

	// read and check latency and byte
	task automatic drive_read(input int ch, input logic [`PSRAM_BYTE_ADDR_W-1:0] addr);
		int n;
		logic [7:0] expected;
		wait_idle(ch);
		@(posedge sys_clk);
		rd[ch]		<= 1'b1;
		address[ch]	<= addr;
		@(posedge sys_clk);
		rd[ch] <= 1'b0;
		expected = ref_mem[ch][addr[REF_W-1:0]];
		reads_issued[ch]++;
		n = 1;
		@(negedge sys_clk);
		while (!rdata_en[ch] && n < OP_CYCLES) begin
			n++;
			@(negedge sys_clk);
		end
		if (!rdata_en[ch]) begin
			errors++;
			$display("%s: rdata%0d_en did not come after a read", test_name, ch);
		end else begin
			check_value($sformatf("ch%0d read latency", ch), LAT + 2, n);
			check_value($sformatf("ch%0d rdata at %0h", ch, addr), expected, rdata[ch]);
		end
		@(negedge sys_clk);
		check_value($sformatf("ch%0d busy after read", ch), 0, busy[ch]);
	endtask

	// a second request while the channel is busy gets dropped
	task automatic poke_while_busy(input int ch, input logic is_wr,
			input logic [`PSRAM_BYTE_ADDR_W-1:0] addr, input logic [7:0] data);
		@(negedge sys_clk);
		while (!busy[ch]) @(negedge sys_clk);
		@(posedge sys_clk);
		wr[ch]		<= is_wr;
		rd[ch]		<= !is_wr;
		address[ch]	<= addr;
		wdata[ch]	<= data;
		@(posedge sys_clk);
		wr[ch] <= 1'b0;
		rd[ch] <= 1'b0;
	endtask

	task automatic random_op(input int ch, input logic [31:0] r);
		logic [`PSRAM_BYTE_ADDR_W-1:0] addr;
		addr = r[`PSRAM_BYTE_ADDR_W-1:0] & ADDR_WINDOW;	// upper bits alias
		if (r[31] && ref_vld[ch][addr[REF_W-1:0]]) begin
			drive_read(ch, addr);
		end else begin
			drive_write(ch, addr, r[29:22]);
		end
	endtask

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial begin
		logic [31:0] r0;
		logic [31:0] r1;
		n_reset		= 1'b0;
		rd			= '0;
		wr			= '0;
		address[0]	= '0;
		address[1]	= '0;
		wdata[0]	= '0;
		wdata[1]	= '0;
		errors		= 0;
		tests_run	= 0;
		tests_failed = 0;
		rng_state	= 32'd60700;
		test_name	= "reset";
		for (int c = 0; c < 2; c++) begin
			reads_issued[c] = 0;
			pulses_seen[c] = 0;
			for (int i = 0; i < (1 << REF_W); i++) ref_vld[c][i] = 1'b0;
		end
		repeat (5) @(posedge sys_clk);
		n_reset <= 1'b1;

		start_test("init");
		for (int k = 0; k < `PSRAM_INIT_CYCLES; k++) begin
			@(negedge sys_clk);
			check_value("initial_busy during init", 1, initial_busy);
			check_value("busy0 during init", 1, busy[0]);
			check_value("busy1 during init", 1, busy[1]);
		end
		@(negedge sys_clk);
		check_value("initial_busy after init", 0, initial_busy);
		check_value("busy0 with init_done", 1, busy[0]);	// one cycle behind
		check_value("busy1 with init_done", 1, busy[1]);
		@(negedge sys_clk);
		check_value("busy0 after init", 0, busy[0]);
		check_value("busy1 after init", 0, busy[1]);
		finish_test();

		start_test("byte_lanes");
		drive_write(0, 22'h000010, 8'h3c);	// even lane
		drive_write(0, 22'h000011, 8'hc5);	// odd lane of the same word
		drive_read(0, 22'h000010);
		drive_read(0, 22'h000011);
		finish_test();

		start_test("timing");
		drive_write(1, 22'h000002, 8'h81);
		drive_write(1, 22'h000005, 8'h7e);
		drive_write(1, 22'h0000ff, 8'h42);
		drive_read(1, 22'h000005);
		drive_read(1, 22'h000002);
		drive_read(1, 22'h0000ff);
		finish_test();

		start_test("independence");
		fork
			drive_write(0, 22'h000020, 8'h11);
			drive_write(1, 22'h000020, 8'h22);
		join
		fork
			drive_read(0, 22'h000020);
			drive_read(1, 22'h000020);
		join
		finish_test();

		start_test("busy_ignore");
		fork
			drive_write(0, 22'h000040, 8'ha5);
			poke_while_busy(0, 1'b1, 22'h000040, 8'h5a);	// dropped write
		join
		fork
			drive_read(0, 22'h000040);
			poke_while_busy(0, 1'b0, 22'h000041, 8'h00);	// dropped read
		join
		drive_read(0, 22'h000040);
		finish_test();

		start_test("random");
		for (int i = 0; i < 200; i++) begin
			rng_state = xorshift32(rng_state);
			r0 = rng_state;
			rng_state = xorshift32(rng_state);
			r1 = rng_state;
			fork
				random_op(0, r0);
				random_op(1, r1);
			join
		end
		finish_test();

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: psram_dual_bridge.f
+incdir+.
psram_pkg.sv
psram_word_if.sv
psram_byte_port.sv
psram_word_core.sv
psram_dual_bridge.sv
tb_psram_dual_bridge.sv
